// File: mem_init_pkg.sv
// ========================================
// Shared sizes for the work-memory banks,
// power-on fill pattern codes, and the
// console address word with its two views
// ========================================

package mem_init_pkg;

	// ========================================
	// Bank geometry
	// ========================================

	localparam int num_banks   = 4;
	localparam int bank_sel_w  = 2;
	// 4096 bytes per bank
	localparam int bank_addr_w = 12;
	localparam int cpu_addr_w  = bank_sel_w + bank_addr_w;
	localparam int data_w      = 8;

	// One write every second cycle over the whole bank
	localparam int fill_pass_cycles = 2 * (2 ** bank_addr_w);

	// ========================================
	// Fill pattern codes
	// ========================================

	localparam int pat_w = 2;

	// Alternating 99/66, as on later consoles
	localparam logic [pat_w-1:0] pat_9966 = 2'd0;
	// Alternating 00/FF, as on early consoles
	localparam logic [pat_w-1:0] pat_00ff = 2'd1;
	localparam logic [pat_w-1:0] pat_55   = 2'd2;
	localparam logic [pat_w-1:0] pat_ff   = 2'd3;

	// ========================================
	// Console address word
	// ========================================

	// Flat byte address, or bank index over offset in bank
	typedef union packed {
		logic [cpu_addr_w-1:0] flat;
		struct packed {
			logic [bank_sel_w-1:0]  bank;
			logic [bank_addr_w-1:0] offset;
		} fields;
	} cpu_addr_u;

endpackage

// File: mem_fill_sequencer.sv
// ========================================
// Clear pass sequencer
// Walks every bank address once after a
// load strobe, one fill write per two cycles
// ========================================

`timescale 1ns/1ps

module mem_fill_sequencer (
	input  logic                                 clk_sys,
	input  logic                                 RESET,
	input  logic                                 load_start,
	output logic                                 clearing,
	output logic [mem_init_pkg::bank_addr_w-1:0] fill_addr,
	output logic                                 fill_we
);

	logic fill_wait;
	logic last_addr;

	assign last_addr = &fill_addr;

	// Write only on the second cycle of each pair
	assign fill_we = clearing & ~fill_wait;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_wait <= 1'b1;
			fill_addr <= '0;
		end else if (!clearing) begin
			// A new pass starts on a wait cycle at address 0
			fill_wait <= 1'b1;
			fill_addr <= '0;
			if (load_start) begin
				clearing <= 1'b1;
			end
		end else begin
			fill_wait <= ~fill_wait;
			if (!fill_wait) begin
				fill_addr <= fill_addr + 1'b1;
				// Pass ends right after the last address is written
				if (last_addr) begin
					clearing <= 1'b0;
				end
			end
		end
	end

	// Clearing drops only after the write to the last address
	pass_ends_at_last: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$fell(clearing) && !$past(RESET) |-> $past(fill_we) && (&$past(fill_addr))
	);

endmodule

// File: access_decoder.sv
// ========================================
// Console access decoder
// Registers one request per cycle, drops it
// during a clear, and turns the bank field
// into one-hot write and read strobes
// ========================================

`timescale 1ns/1ps

module access_decoder (
	input  logic                                 clk_sys,
	input  logic                                 RESET,
	input  logic                                 clearing,
	input  logic                                 load_start,
	input  mem_init_pkg::cpu_addr_u              cpu_addr,
	input  logic [mem_init_pkg::data_w-1:0]      cpu_wdata,
	input  logic                                 cpu_we,
	input  logic                                 cpu_rd,
	output logic [mem_init_pkg::num_banks-1:0]   bank_wr,
	output logic [mem_init_pkg::num_banks-1:0]   bank_rd,
	output logic [mem_init_pkg::bank_addr_w-1:0] bank_offset,
	output logic [mem_init_pkg::data_w-1:0]      bank_wdata
);

	logic                               accept;
	logic [mem_init_pkg::num_banks-1:0] bank_hot;

	// Nothing gets through while the banks are owned by the fill pass
	assign accept = ~clearing & ~load_start;

	assign bank_hot = mem_init_pkg::num_banks'(1) << cpu_addr.fields.bank;

	// ========================================
	// Strobes
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bank_wr <= '0;
			bank_rd <= '0;
		end else begin
			bank_wr <= '0;
			bank_rd <= '0;
			if (accept) begin
				// Write wins when both strobes come together
				if (cpu_we) begin
					bank_wr <= bank_hot;
				end else if (cpu_rd) begin
					bank_rd <= bank_hot;
				end
			end
		end
	end

	// Offset and data only move with a request
	always_ff @(posedge clk_sys) begin
		if (cpu_we | cpu_rd) begin
			bank_offset <= cpu_addr.fields.offset;
			bank_wdata  <= cpu_wdata;
		end
	end

	// One bank op at a time, and none while the sequencer owns the banks
	strobe_onehot: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$onehot0({bank_wr, bank_rd}) && !(clearing && |{bank_wr, bank_rd})
	);

endmodule

// File: ram_bank.sv
// ========================================
// One work-memory bank
// 4 KB byte array, power-on fill pattern
// generator, console write and a
// registered read port
// ========================================

`timescale 1ns/1ps

module ram_bank (
	input  logic                                 clk_sys,
	input  logic                                 RESET,
	input  logic [mem_init_pkg::pat_w-1:0]       pattern,
	input  logic [mem_init_pkg::bank_addr_w-1:0] fill_addr,
	input  logic                                 fill_we,
	input  logic                                 bank_wr,
	input  logic                                 bank_rd,
	input  logic [mem_init_pkg::bank_addr_w-1:0] bank_offset,
	input  logic [mem_init_pkg::data_w-1:0]      bank_wdata,
	output logic [mem_init_pkg::data_w-1:0]      rd_data,
	output logic                                 rd_valid
);

	logic [mem_init_pkg::data_w-1:0] mem [0:(2 ** mem_init_pkg::bank_addr_w)-1];
	logic [mem_init_pkg::data_w-1:0] fill_byte;

	// ========================================
	// Fill pattern generator
	// ========================================

	always_comb begin
		case (pattern)
			mem_init_pkg::pat_9966: begin
				fill_byte = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			end
			mem_init_pkg::pat_00ff: begin
				fill_byte = (fill_addr[9] ^ fill_addr[0]) ? 8'hff : 8'h00;
			end
			mem_init_pkg::pat_55: begin
				fill_byte = 8'h55;
			end
			default: begin
				fill_byte = 8'hff;
			end
		endcase
	end

	// ========================================
	// Array access
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (fill_we) begin
			mem[fill_addr] <= fill_byte;
		end else if (bank_wr) begin
			mem[bank_offset] <= bank_wdata;
		end
	end

	// Read data sits one cycle behind the bank strobe
	always_ff @(posedge clk_sys) begin
		if (bank_rd) begin
			rd_data <= mem[bank_offset];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= bank_rd;
		end
	end

	// Decoder and sequencer must never share a cycle on the array
	no_fill_overlap: assert property (
		@(posedge clk_sys) disable iff (RESET)
		fill_we |-> !(bank_wr || bank_rd)
	);

endmodule

// File: read_return_selector.sv
// ========================================
// Read return selector
// Picks the byte of the bank that answered
// and registers it with the valid flag
// ========================================

`timescale 1ns/1ps

module read_return_selector (
	input  logic                                                  clk_sys,
	input  logic                                                  RESET,
	input  logic [mem_init_pkg::num_banks-1:0][mem_init_pkg::data_w-1:0] rd_data,
	input  logic [mem_init_pkg::num_banks-1:0]                    rd_valid,
	output logic [mem_init_pkg::data_w-1:0]                       cpu_rdata,
	output logic                                                  cpu_rvalid
);

	logic [mem_init_pkg::data_w-1:0] sel_data;

	// AND-OR mux, at most one bank answers per cycle
	always_comb begin
		sel_data = '0;
		for (int i = 0; i < mem_init_pkg::num_banks; i++) begin
			if (rd_valid[i]) begin
				sel_data = sel_data | rd_data[i];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (|rd_valid) begin
			cpu_rdata <= sel_data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cpu_rvalid <= 1'b0;
		end else begin
			cpu_rvalid <= |rd_valid;
		end
	end

	// Decoder sends one read per cycle, so banks answer one at a time
	single_return: assert property (
		@(posedge clk_sys) disable iff (RESET)
		$onehot0(rd_valid)
	);

endmodule

// File: mem_init_top.sv
// ========================================
// Cartridge load memory init subsystem
// Clear sequencer, access decoder, four
// work-memory banks and the read return
// ========================================

`timescale 1ns/1ps

module mem_init_top (
	input  logic                                                clk_sys,
	input  logic                                                RESET,
	input  logic                                                load_start,
	input  logic [mem_init_pkg::num_banks*mem_init_pkg::pat_w-1:0] fill_patterns,
	input  logic [mem_init_pkg::cpu_addr_w-1:0]                 cpu_addr,
	input  logic [mem_init_pkg::data_w-1:0]                     cpu_wdata,
	input  logic                                                cpu_we,
	input  logic                                                cpu_rd,
	output logic                                                clearing,
	output logic [mem_init_pkg::data_w-1:0]                     cpu_rdata,
	output logic                                                cpu_rvalid
);

	mem_init_pkg::cpu_addr_u                   cpu_word;
	logic [mem_init_pkg::bank_addr_w-1:0]      fill_addr;
	logic                                      fill_we;
	logic [mem_init_pkg::num_banks-1:0]        bank_wr;
	logic [mem_init_pkg::num_banks-1:0]        bank_rd;
	logic [mem_init_pkg::bank_addr_w-1:0]      bank_offset;
	logic [mem_init_pkg::data_w-1:0]           bank_wdata;
	logic [mem_init_pkg::num_banks-1:0][mem_init_pkg::data_w-1:0] bank_rdata;
	logic [mem_init_pkg::num_banks-1:0]        bank_rvalid;

	// Console drives a flat address, the decoder reads it as bank and offset
	assign cpu_word.flat = cpu_addr;

	mem_fill_sequencer i_mem_fill_sequencer (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.load_start (load_start),
		.clearing   (clearing),
		.fill_addr  (fill_addr),
		.fill_we    (fill_we)
	);

	access_decoder i_access_decoder (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.clearing    (clearing),
		.load_start  (load_start),
		.cpu_addr    (cpu_word),
		.cpu_wdata   (cpu_wdata),
		.cpu_we      (cpu_we),
		.cpu_rd      (cpu_rd),
		.bank_wr     (bank_wr),
		.bank_rd     (bank_rd),
		.bank_offset (bank_offset),
		.bank_wdata  (bank_wdata)
	);

	// Each bank picks its own fill pattern from its slice
	for (genvar i = 0; i < mem_init_pkg::num_banks; i++) begin : g_bank
		ram_bank i_ram_bank (
			.clk_sys     (clk_sys),
			.RESET       (RESET),
			.pattern     (fill_patterns[i*mem_init_pkg::pat_w +: mem_init_pkg::pat_w]),
			.fill_addr   (fill_addr),
			.fill_we     (fill_we),
			.bank_wr     (bank_wr[i]),
			.bank_rd     (bank_rd[i]),
			.bank_offset (bank_offset),
			.bank_wdata  (bank_wdata),
			.rd_data     (bank_rdata[i]),
			.rd_valid    (bank_rvalid[i])
		);
	end

	read_return_selector i_read_return_selector (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.rd_data    (bank_rdata),
		.rd_valid   (bank_rvalid),
		.cpu_rdata  (cpu_rdata),
		.cpu_rvalid (cpu_rvalid)
	);

endmodule

// File: tb_mem_init.sv
// ========================================
// Testbench for the memory init subsystem
// Clock, LFSR, request tasks, fill byte
// reference, shadow memory, and a process
// that compares read responses
// ========================================

`timescale 1ns/1ps

module tb_mem_init;

	logic clk_sys;
	logic RESET;
	logic load_start;
	logic [mem_init_pkg::num_banks*mem_init_pkg::pat_w-1:0] fill_patterns;
	logic [mem_init_pkg::cpu_addr_w-1:0] cpu_addr;
	logic [mem_init_pkg::data_w-1:0] cpu_wdata;
	logic cpu_we;
	logic cpu_rd;
	logic clearing;
	logic [mem_init_pkg::data_w-1:0] cpu_rdata;
	logic cpu_rvalid;

	logic [31:0] lfsr = 32'hcfe2_00ab;
	logic [31:0] v;
	logic [mem_init_pkg::num_banks*mem_init_pkg::pat_w-1:0] pats;
	logic [mem_init_pkg::data_w-1:0] shadow [0:(2 ** mem_init_pkg::cpu_addr_w)-1];
	logic [mem_init_pkg::data_w-1:0] exp_data [$];
	int exp_due [$];
	logic [mem_init_pkg::cpu_addr_w-1:0] wr_addrs [$];
	logic [mem_init_pkg::cpu_addr_w-1:0] stray_addrs [$];
	mem_init_pkg::cpu_addr_u word;
	int cycle = 0;
	int data_errs = 0;
	int resp_errs = 0;
	int clear_errs = 0;
	int timeout_errs = 0;

	mem_init_top i_mem_init_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// Taps 32, 22, 2, 1
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] r);
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
	endtask

	// Expected power-on byte at offset a inside a bank
	function automatic logic [7:0] fill_ref(input logic [1:0] pat, input logic [11:0] a);
		case (pat)
			mem_init_pkg::pat_9966: fill_ref = (a[8] != a[2]) ? 8'h66 : 8'h99;
			mem_init_pkg::pat_00ff: fill_ref = (a[9] != a[0]) ? 8'hff : 8'h00;
			mem_init_pkg::pat_55: fill_ref = 8'h55;
			default: fill_ref = 8'hff;
		endcase
	endfunction

	task automatic finish_run;
		$display("Errors: data %0d, response %0d, clear %0d, timeout %0d",
			data_errs, resp_errs, clear_errs, timeout_errs);
		if (data_errs + resp_errs + clear_errs + timeout_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	// Next drive point 2 ns after the edge with strobes back at idle
	task automatic step;
		@(posedge clk_sys);
		#2;
		load_start = 1'b0;
		cpu_we = 1'b0;
		cpu_rd = 1'b0;
	endtask

	task automatic issue_write(input logic [13:0] a, input logic [7:0] d, input bit with_rd);
		cpu_addr = a;
		cpu_wdata = d;
		cpu_we = 1'b1;
		cpu_rd = with_rd;
		shadow[a] = d;
		step();
	endtask

	task automatic issue_read(input logic [13:0] a);
		cpu_addr = a;
		cpu_rd = 1'b1;
		exp_data.push_back(shadow[a]);
		// Visible after the third edge from here
		exp_due.push_back(cycle + 3);
		step();
	endtask

	task automatic random_reads(input int n);
		logic [31:0] r;
		repeat (n) begin
			take_bits(14, r);
			issue_read(r[13:0]);
		end
	endtask

	task automatic drain;
		while (exp_due.size() > 0) begin
			step();
		end
	endtask

	task automatic run_clear(input logic [7:0] p, input bit stray);
		int start;
		logic [31:0] r;
		fill_patterns = p;
		load_start = 1'b1;
		if (stray) begin
			// Read in the load cycle itself
			take_bits(14, r);
			cpu_addr = r[13:0];
			cpu_rd = 1'b1;
		end
		start = cycle;
		step();
		while (clearing === 1'b1) begin
			take_bits(6, r);
			if (stray && r[5:0] == 6'd0) begin
				take_bits(23, r);
				cpu_addr = r[13:0];
				cpu_wdata = r[21:14];
				cpu_we = r[22];
				cpu_rd = ~r[22];
				if (r[22]) begin
					stray_addrs.push_back(r[13:0]);
				end
			end
			step();
		end
		assert (cycle - start - 1 == mem_init_pkg::fill_pass_cycles) else begin
			clear_errs++;
			$display("Fail at %0d ns: clearing high for %0d cycles, expected %0d",
				$time, cycle - start - 1, mem_init_pkg::fill_pass_cycles);
		end
		for (int b = 0; b < mem_init_pkg::num_banks; b++) begin
			for (int o = 0; o < 2 ** mem_init_pkg::bank_addr_w; o++) begin
				word.fields.bank = b[1:0];
				word.fields.offset = o[11:0];
				shadow[word.flat] = fill_ref(p[b*mem_init_pkg::pat_w +: mem_init_pkg::pat_w],
					o[11:0]);
			end
		end
	endtask

	// ========================================
	// Response checker and timeout
	// ========================================

	always @(negedge clk_sys) begin
		if (!RESET) begin
			if (exp_due.size() > 0 && exp_due[0] == cycle) begin
				assert (cpu_rvalid === 1'b1) else begin
					resp_errs++;
					$display("Fail at %0d ns: cpu_rvalid = %b, expected 1", $time, cpu_rvalid);
				end
				assert (cpu_rdata === exp_data[0]) else begin
					data_errs++;
					$display("Fail at %0d ns: cpu_rdata = %02h, expected %02h",
						$time, cpu_rdata, exp_data[0]);
				end
				void'(exp_due.pop_front());
				void'(exp_data.pop_front());
			end else begin
				assert (cpu_rvalid === 1'b0) else begin
					resp_errs++;
					$display("Fail at %0d ns: cpu_rvalid = %b, expected 0", $time, cpu_rvalid);
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle >= 4 * mem_init_pkg::fill_pass_cycles + 2000) begin
			timeout_errs++;
			$display("Timeout: run still busy after %0d cycles", cycle);
			finish_run();
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		RESET = 1'b1;
		load_start = 1'b0;
		fill_patterns = '0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_we = 1'b0;
		cpu_rd = 1'b0;
		repeat (8) @(posedge clk_sys);
		#2;
		RESET = 1'b0;
		// Nothing may move while idle after reset
		repeat (16) begin
			step();
			assert (clearing === 1'b0) else begin
				clear_errs++;
				$display("Fail at %0d ns: clearing = %b, expected 0", $time, clearing);
			end
		end
		take_bits(8, v);
		pats = v[7:0];
		run_clear(pats, 1'b0);
		random_reads(64);
		drain();
		// Writes, then read back with untouched addresses mixed in
		repeat (40) begin
			take_bits(22, v);
			issue_write(v[13:0], v[21:14], 1'b0);
			wr_addrs.push_back(v[13:0]);
		end
		foreach (wr_addrs[i]) begin
			issue_read(wr_addrs[i]);
		end
		random_reads(40);
		drain();
		// Back to back write and read, plus the same offset in the next bank
		repeat (24) begin
			take_bits(30, v);
			issue_write(v[13:0], v[21:14], 1'b0);
			issue_read(v[13:0]);
			word.flat = v[13:0];
			word.fields.bank = word.fields.bank + 2'd1;
			issue_read(word.flat);
			issue_write(word.flat, v[29:22], 1'b1);
			issue_read(word.flat);
		end
		random_reads(16);
		drain();
		// Requests during a pass are dropped
		take_bits(8, v);
		pats = v[7:0];
		run_clear(pats, 1'b1);
		foreach (stray_addrs[i]) begin
			issue_read(stray_addrs[i]);
		end
		random_reads(32);
		drain();
		// Second load wipes earlier writes
		foreach (wr_addrs[i]) begin
			take_bits(8, v);
			issue_write(wr_addrs[i], v[7:0], 1'b0);
		end
		take_bits(8, v);
		if (v[7:0] == pats) begin
			v[7:0] = ~pats;
		end
		run_clear(v[7:0], 1'b0);
		foreach (wr_addrs[i]) begin
			issue_read(wr_addrs[i]);
		end
		random_reads(32);
		drain();
		repeat (4) step();
		finish_run();
	end

endmodule

// File: files.f
mem_init_pkg.sv
mem_fill_sequencer.sv
access_decoder.sv
ram_bank.sv
read_return_selector.sv
mem_init_top.sv
tb_mem_init.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_init \
	-f files.f \
	-o tb_mem_init

# The pass line in the output decides the result
out=$(./obj_dir/tb_mem_init || true)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
